// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mips_cpu_execute_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/mips_cpu_alu.sv
`timescale 1ns/1ps

module mips_cpu_alu (
    input  mips_cpu_pkg::word_t   rs,
    input  mips_cpu_pkg::word_t   rt,
    input  logic [4:0]            shift,
    input  mips_cpu_pkg::alu_op_t alu_ctrl,
    output mips_cpu_pkg::word_t   alu_out,
    output mips_cpu_pkg::word_t   alu_lo,
    output mips_cpu_pkg::word_t   alu_hi
);

    import mips_cpu_pkg::*;

    logic [4:0] var_shift;
    logic       div_zero;
    logic       div_ovf;    // most negative over minus one

    assign var_shift = rt[4:0];
    assign div_zero  = (rt == '0);
    assign div_ovf   = (rs == {1'b1, {(xlen-1){1'b0}}}) && (rt == '1);

    always_comb begin
        alu_out = '0;
        alu_hi  = '0;
        alu_lo  = '0;
        case (alu_ctrl)
            alu_add:   alu_out = rs + rt;   // wraps without trapping
            alu_sub:   alu_out = rs - rt;
            alu_mul_s: {alu_hi, alu_lo} = $signed(rs) * $signed(rt);
            alu_mul_u: {alu_hi, alu_lo} = rs * rt;
            alu_div_s: begin
                if (div_zero) begin
                    alu_lo = '1;
                    alu_hi = rs;
                end else if (div_ovf) begin
                    alu_lo = rs;
                end else begin
                    alu_lo = $signed(rs) / $signed(rt);
                    alu_hi = $signed(rs) % $signed(rt);  // sign of dividend
                end
            end
            alu_div_u: begin
                if (div_zero) begin
                    alu_lo = '1;
                    alu_hi = rs;
                end else begin
                    alu_lo = rs / rt;
                    alu_hi = rs % rt;
                end
            end
            alu_and:  alu_out = rs & rt;
            alu_or:   alu_out = rs | rt;
            alu_xor:  alu_out = rs ^ rt;
            alu_sll:  alu_out = rs << shift;
            alu_sllv: alu_out = rs << var_shift;
            alu_srl:  alu_out = rs >> shift;
            alu_srlv: alu_out = rs >> var_shift;
            alu_sra:  alu_out = $signed(rs) >>> shift;
            alu_srav: alu_out = $signed(rs) >>> var_shift;
            alu_eq:   alu_out = {{(xlen-1){1'b0}}, rs == rt};
            alu_gez:  alu_out = {{(xlen-1){1'b0}}, !rs[xlen-1]};
            alu_gtz:  alu_out = {{(xlen-1){1'b0}}, !rs[xlen-1] && (rs != '0)};
            alu_lez:  alu_out = {{(xlen-1){1'b0}}, rs[xlen-1] || (rs == '0)};
            alu_ltz:  alu_out = {{(xlen-1){1'b0}}, rs[xlen-1]};
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(rs) < $signed(rt)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, rs < rt};
            alu_ne:   alu_out = {{(xlen-1){1'b0}}, rs != rt};
            alu_pass_rs: alu_out = rs;      // mthi, mtlo
            alu_one:     alu_out = 32'd1;
            alu_lui:     alu_out = rt << 16;
            default:     alu_out = '0;      // undecoded gives 0
        endcase
    end

endmodule

// File: hw/mips_cpu_alu_control.sv
`timescale 1ns/1ps

module mips_cpu_alu_control (
    input  logic                   in_valid,
    input  mips_cpu_pkg::word_t    instr,
    output mips_cpu_pkg::alu_op_t  alu_op,
    output logic                   use_imm,
    output logic                   imm_zext,
    output logic                   hi_wen,
    output logic                   lo_wen,
    output logic                   hi_src_alu,
    output logic                   wen_q,
    output mips_cpu_pkg::res_sel_t res_sel,
    output mips_cpu_pkg::reg_idx_t dest
);

    import mips_cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt_field;
    logic       wen;    // before in_valid
    logic       hi_we;
    logic       lo_we;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign rt_field = instr[20:16];

    always_comb begin
        alu_op     = alu_op_t'(5'h1f);  // no such op so the alu gives 0
        use_imm    = 1'b0;
        imm_zext   = 1'b0;
        res_sel    = res_alu;
        hi_src_alu = 1'b1;
        hi_we      = 1'b0;
        lo_we      = 1'b0;
        wen        = 1'b0;
        dest       = rt_field;          // i-type default
        case (opcode)
            op_special: begin
                dest = instr[15:11];    // rd
                wen  = 1'b1;
                case (funct)
                    fn_add, fn_addu: alu_op = alu_add;
                    fn_sub, fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    fn_sllv: alu_op = alu_sllv;
                    fn_srlv: alu_op = alu_srlv;
                    fn_srav: alu_op = alu_srav;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_mult, fn_multu, fn_div, fn_divu: begin
                        alu_op = (funct == fn_mult)  ? alu_mul_s :
                                 (funct == fn_multu) ? alu_mul_u :
                                 (funct == fn_div)   ? alu_div_s : alu_div_u;
                        wen   = 1'b0;
                        hi_we = 1'b1;
                        lo_we = 1'b1;
                    end
                    fn_mfhi: res_sel = res_hi;
                    fn_mflo: res_sel = res_lo;
                    fn_mthi, fn_mtlo: begin
                        alu_op     = alu_pass_rs;
                        hi_src_alu = 1'b0;      // take rs through alu_out
                        wen        = 1'b0;
                        hi_we      = (funct == fn_mthi);
                        lo_we      = (funct == fn_mtlo);
                    end
                    fn_jr: begin
                        alu_op = alu_one;
                        wen    = 1'b0;
                    end
                    default: wen = 1'b0;
                endcase
            end
            op_regimm: begin
                if (rt_field == rt_bltz) begin
                    alu_op = alu_ltz;
                end else if (rt_field == rt_bgez) begin
                    alu_op = alu_gez;
                end
            end
            op_beq:  alu_op = alu_eq;
            op_bne:  alu_op = alu_ne;
            op_blez: alu_op = alu_lez;
            op_bgtz: alu_op = alu_gtz;
            op_j:    alu_op = alu_one;
            op_jal: begin
                alu_op = alu_one;
                dest   = link_reg;
                wen    = 1'b1;
            end
            op_addi, op_addiu, op_slti, op_sltiu: begin
                alu_op  = (opcode == op_slti)  ? alu_slt :
                          (opcode == op_sltiu) ? alu_sltu : alu_add;
                use_imm = 1'b1;
                wen     = 1'b1;
            end
            op_andi, op_ori, op_xori, op_lui: begin
                alu_op   = (opcode == op_andi) ? alu_and :
                           (opcode == op_ori)  ? alu_or  :
                           (opcode == op_xori) ? alu_xor : alu_lui;
                use_imm  = 1'b1;
                imm_zext = 1'b1;
                wen      = 1'b1;
            end
            default: ;
        endcase
    end

    assign wen_q  = wen & in_valid;
    assign hi_wen = hi_we & in_valid;
    assign lo_wen = lo_we & in_valid;

endmodule

// File: hw/mips_cpu_execute.sv
`timescale 1ns/1ps

module mips_cpu_execute (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  mips_cpu_pkg::word_t    instr,
    input  mips_cpu_pkg::word_t    rs_val,
    input  mips_cpu_pkg::word_t    rt_val,
    output logic                   out_valid,
    output logic                   out_wen,
    output mips_cpu_pkg::word_t    result,
    output mips_cpu_pkg::word_t    hi,
    output mips_cpu_pkg::word_t    lo,
    output mips_cpu_pkg::reg_idx_t out_dest
);

    import mips_cpu_pkg::*;

    alu_op_t  alu_op;
    res_sel_t res_sel;
    reg_idx_t dest;
    logic     use_imm;
    logic     imm_zext;
    logic     hi_wen;
    logic     lo_wen;
    logic     hi_src_alu;
    logic     wen_q;
    word_t    op_b;
    word_t    alu_out;
    word_t    alu_hi;
    word_t    alu_lo;
    word_t    wb_val;

    mips_cpu_alu_control u_ctrl (
        .in_valid   (in_valid),
        .instr      (instr),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .imm_zext   (imm_zext),
        .hi_wen     (hi_wen),
        .lo_wen     (lo_wen),
        .hi_src_alu (hi_src_alu),
        .wen_q      (wen_q),
        .res_sel    (res_sel),
        .dest       (dest)
    );

    mips_cpu_operand_sel u_opsel (
        .use_imm  (use_imm),
        .imm_zext (imm_zext),
        .rt_val   (rt_val),
        .imm      (instr[15:0]),
        .op_b     (op_b)
    );

    mips_cpu_alu u_alu (
        .rs       (rs_val),
        .rt       (op_b),
        .shift    (instr[10:6]),    // shamt
        .alu_ctrl (alu_op),
        .alu_out  (alu_out),
        .alu_lo   (alu_lo),
        .alu_hi   (alu_hi)
    );

    mips_cpu_hilo u_hilo (
        .clk        (clk),
        .arst_n     (arst_n),
        .hi_wen     (hi_wen),
        .lo_wen     (lo_wen),
        .hi_src_alu (hi_src_alu),
        .alu_out    (alu_out),
        .alu_hi     (alu_hi),
        .alu_lo     (alu_lo),
        .res_sel    (res_sel),
        .hi         (hi),
        .lo         (lo),
        .wb_val     (wb_val)
    );

    mips_cpu_stage_reg #(.payload_t(word_t)) u_res_reg (
        .clk     (clk),
        .arst_n  (arst_n),
        .d_valid (in_valid),
        .d       (wb_val),
        .q_valid (out_valid),
        .q       (result)
    );

    // wen_q already carries in_valid
    mips_cpu_stage_reg #(.payload_t(reg_idx_t)) u_dest_reg (
        .clk     (clk),
        .arst_n  (arst_n),
        .d_valid (wen_q),
        .d       (dest),
        .q_valid (out_wen),
        .q       (out_dest)
    );

endmodule

// File: hw/mips_cpu_hilo.sv
`timescale 1ns/1ps

module mips_cpu_hilo (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   hi_wen,
    input  logic                   lo_wen,
    input  logic                   hi_src_alu,
    input  mips_cpu_pkg::word_t    alu_out,
    input  mips_cpu_pkg::word_t    alu_hi,
    input  mips_cpu_pkg::word_t    alu_lo,
    input  mips_cpu_pkg::res_sel_t res_sel,
    output mips_cpu_pkg::word_t    hi,
    output mips_cpu_pkg::word_t    lo,
    output mips_cpu_pkg::word_t    wb_val
);

    import mips_cpu_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (hi_wen) begin
                hi <= hi_src_alu ? alu_hi : alu_out;  // mult/div or mthi
            end
            if (lo_wen) begin
                lo <= hi_src_alu ? alu_lo : alu_out;
            end
        end
    end

    // mfhi and mflo read the registers as they stand
    always_comb begin
        case (res_sel)
            res_hi:  wb_val = hi;
            res_lo:  wb_val = lo;
            default: wb_val = alu_out;
        endcase
    end

endmodule

// File: hw/mips_cpu_operand_sel.sv
`timescale 1ns/1ps

module mips_cpu_operand_sel (
    input  logic                use_imm,
    input  logic                imm_zext,
    input  mips_cpu_pkg::word_t rt_val,
    input  logic [15:0]         imm,
    output mips_cpu_pkg::word_t op_b
);

    import mips_cpu_pkg::*;

    word_t imm_sext;
    word_t imm_uext;

    assign imm_sext = {{(xlen-16){imm[15]}}, imm};  // addi, addiu, slti, sltiu
    assign imm_uext = {{(xlen-16){1'b0}}, imm};     // logic ops and lui

    // branches and r-type keep rt_val
    assign op_b = use_imm ? (imm_zext ? imm_uext : imm_sext) : rt_val;

endmodule

// File: hw/mips_cpu_pkg.sv
package mips_cpu_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // fixed numbering of the alu select codes
    typedef enum logic [4:0] {
        alu_add     = 5'd0,
        alu_sub     = 5'd1,
        alu_mul_s   = 5'd2,
        alu_mul_u   = 5'd3,
        alu_div_s   = 5'd4,
        alu_div_u   = 5'd5,
        alu_and     = 5'd6,
        alu_or      = 5'd7,
        alu_xor     = 5'd8,
        alu_sll     = 5'd9,
        alu_sllv    = 5'd10,
        alu_srl     = 5'd11,
        alu_srlv    = 5'd12,
        alu_sra     = 5'd13,
        alu_srav    = 5'd14,
        alu_eq      = 5'd15,
        alu_gez     = 5'd16,
        alu_gtz     = 5'd17,
        alu_lez     = 5'd18,
        alu_ltz     = 5'd19,
        alu_slt     = 5'd20,
        alu_sltu    = 5'd21,
        alu_ne      = 5'd22,
        alu_pass_rs = 5'd23,
        alu_one     = 5'd24,  // jumps
        alu_lui     = 5'd25
    } alu_op_t;

    typedef enum logic [1:0] {
        res_alu = 2'd0,
        res_hi  = 2'd1,
        res_lo  = 2'd2
    } res_sel_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;

    // funct field of special
    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_srl   = 6'h02;
    localparam logic [5:0] fn_sra   = 6'h03;
    localparam logic [5:0] fn_sllv  = 6'h04;
    localparam logic [5:0] fn_srlv  = 6'h06;
    localparam logic [5:0] fn_srav  = 6'h07;
    localparam logic [5:0] fn_jr    = 6'h08;
    localparam logic [5:0] fn_mfhi  = 6'h10;
    localparam logic [5:0] fn_mthi  = 6'h11;
    localparam logic [5:0] fn_mflo  = 6'h12;
    localparam logic [5:0] fn_mtlo  = 6'h13;
    localparam logic [5:0] fn_mult  = 6'h18;
    localparam logic [5:0] fn_multu = 6'h19;
    localparam logic [5:0] fn_div   = 6'h1a;
    localparam logic [5:0] fn_divu  = 6'h1b;
    localparam logic [5:0] fn_add   = 6'h20;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_sub   = 6'h22;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_xor   = 6'h26;
    localparam logic [5:0] fn_slt   = 6'h2a;
    localparam logic [5:0] fn_sltu  = 6'h2b;

    // rt field under regimm
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    localparam reg_idx_t link_reg = 5'd31;

endpackage

// File: hw/mips_cpu_stage_reg.sv
`timescale 1ns/1ps

module mips_cpu_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     d_valid,
    input  payload_t d,
    output logic     q_valid,
    output payload_t q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_valid <= 1'b0;
            q       <= '0;
        end else begin
            q_valid <= d_valid;
            if (d_valid) begin
                q <= d;     // holds otherwise
            end
        end
    end

endmodule

// File: sim/mips_cpu_execute_checker.sv
`timescale 1ns/1ps

module mips_cpu_execute_checker (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic out_valid,
    input logic out_wen
);

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid && !out_wen)
        else $error("out_valid or out_wen high during reset");

    // a register write only comes with a valid result
    a_wen_valid: assert property (@(posedge clk) disable iff (!arst_n) out_wen |-> out_valid)
        else $error("out_wen high without out_valid");

    a_valid_follow: assert property (@(posedge clk) disable iff (!arst_n) in_valid |=> out_valid)
        else $error("out_valid missing one cycle after in_valid");

    a_no_extra: assert property (@(posedge clk) disable iff (!arst_n) !in_valid |=> !out_valid)
        else $error("out_valid high without a strobe one cycle earlier");

endmodule

bind mips_cpu_execute mips_cpu_execute_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_wen   (out_wen)
);

// File: sim/mips_cpu_execute_tb.sv
`timescale 1ns/1ps

module mips_cpu_execute_tb;

    import mips_cpu_pkg::*;

    localparam int n_per_test = 200;
    localparam int n_tests    = 6;
    localparam int max_cycles = 5 + n_tests * (n_per_test + 1) + 50;

    localparam logic [5:0] arith_fn [7] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
                                            fn_xor};
    localparam logic [5:0] arith_op [6] = '{op_addi, op_addiu, op_andi, op_ori, op_xori, op_lui};
    localparam logic [5:0] shift_fn [6] = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
    localparam logic [5:0] cmp_op [6]   = '{op_slti, op_sltiu, op_beq, op_bne, op_blez, op_bgtz};
    localparam logic [5:0] muldiv_fn [4] = '{fn_mult, fn_multu, fn_div, fn_divu};
    localparam logic [5:0] move_fn [4]  = '{fn_mthi, fn_mtlo, fn_mfhi, fn_mflo};
    localparam logic [5:0] undef_fn [4] = '{6'h01, 6'h05, 6'h0c, 6'h3f};

    logic     clk = 1'b0;
    logic     arst_n;
    logic     in_valid;
    word_t    instr;
    word_t    rs_val;
    word_t    rt_val;
    logic     out_valid;
    logic     out_wen;
    word_t    result;
    word_t    hi;
    word_t    lo;
    reg_idx_t out_dest;

    word_t    m_hi;         // model hi/lo
    word_t    m_lo;
    logic     pend_valid;   // expectation for the next registered cycle
    logic     pend_wen;
    word_t    pend_res;
    reg_idx_t pend_dest;
    int       err_count;
    int       test_errs;
    int       check_count;
    int       cycle_cnt;

    mips_cpu_execute i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .out_valid (out_valid),
        .out_wen   (out_wen),
        .result    (result),
        .hi        (hi),
        .lo        (lo),
        .out_dest  (out_dest)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic divide(input word_t a, input word_t b, input logic sgn);
        word_t ma;
        word_t mb;
        ma = (sgn && a[31]) ? -a : a;   // magnitudes for signed
        mb = (sgn && b[31]) ? -b : b;
        if (b == '0) begin
            m_lo = '1;
            m_hi = a;
        end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            m_lo = a;
            m_hi = '0;
        end else begin
            m_lo = (sgn && (a[31] ^ b[31])) ? -(ma / mb) : ma / mb;
            m_hi = (sgn && a[31]) ? -(ma % mb) : ma % mb;   // remainder follows dividend
        end
    endtask

    task automatic model_step(input logic v, input word_t ins, input word_t a, input word_t b);
        logic [5:0] op;
        logic [5:0] fn;
        word_t      imm_s;
        word_t      imm_z;
        word_t      res;
        logic       wen;
        reg_idx_t   dst;
        op    = ins[31:26];
        fn    = ins[5:0];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        imm_z = {16'h0000, ins[15:0]};
        res   = '0;
        dst   = ins[20:16];     // rt for i-type
        if (op == op_special) begin
            dst = ins[15:11];
            wen = fn inside {fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_sll,
                             fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav, fn_slt, fn_sltu,
                             fn_mfhi, fn_mflo};
        end else begin
            wen = op inside {op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori,
                             op_lui, op_jal};
            if (op == op_jal) begin
                dst = link_reg;
            end
        end
        if (v) begin
            case (op)
                op_special: begin
                    case (fn)
                        fn_add, fn_addu: res = a + b;
                        fn_sub, fn_subu: res = a - b;
                        fn_and:   res = a & b;
                        fn_or:    res = a | b;
                        fn_xor:   res = a ^ b;
                        fn_sll:   res = a << ins[10:6];
                        fn_srl:   res = a >> ins[10:6];
                        fn_sra:   res = $signed(a) >>> ins[10:6];
                        fn_sllv:  res = a << b[4:0];
                        fn_srlv:  res = a >> b[4:0];
                        fn_srav:  res = $signed(a) >>> b[4:0];
                        fn_slt:   res = word_t'($signed(a) < $signed(b));
                        fn_sltu:  res = word_t'(a < b);
                        fn_mult:  {m_hi, m_lo} = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                        fn_multu: {m_hi, m_lo} = {32'h0, a} * {32'h0, b};
                        fn_div:   divide(a, b, 1'b1);
                        fn_divu:  divide(a, b, 1'b0);
                        fn_mfhi:  res = m_hi;
                        fn_mflo:  res = m_lo;
                        fn_mthi: begin
                            res  = a;       // rs passes through the alu
                            m_hi = a;
                        end
                        fn_mtlo: begin
                            res  = a;
                            m_lo = a;
                        end
                        fn_jr:    res = 32'd1;
                        default:  res = '0;
                    endcase
                end
                op_regimm: begin
                    if (ins[20:16] == rt_bltz) begin
                        res = word_t'(a[31]);
                    end else if (ins[20:16] == rt_bgez) begin
                        res = word_t'(!a[31]);
                    end
                end
                op_beq:   res = word_t'(a == b);
                op_bne:   res = word_t'(a != b);
                op_blez:  res = word_t'(a[31] || a == '0);
                op_bgtz:  res = word_t'(!a[31] && a != '0);
                op_j, op_jal: res = 32'd1;
                op_addi, op_addiu: res = a + imm_s;
                op_slti:  res = word_t'($signed(a) < $signed(imm_s));
                op_sltiu: res = word_t'(a < imm_s);
                op_andi:  res = a & imm_z;
                op_ori:   res = a | imm_z;
                op_xori:  res = a ^ imm_z;
                op_lui:   res = {ins[15:0], 16'h0000};
                default:  res = '0;
            endcase
        end
        pend_valid = v;
        pend_wen   = wen & v;
        pend_res   = res;
        pend_dest  = dst;
    endtask

    task automatic check_outputs();
        compare("out_valid", word_t'(out_valid), word_t'(pend_valid));
        compare("out_wen", word_t'(out_wen), word_t'(pend_wen));
        compare("hi", hi, m_hi);
        compare("lo", lo, m_lo);
        if (pend_valid) begin
            compare("result", result, pend_res);
        end
        if (pend_wen) begin
            compare("out_dest", word_t'(out_dest), word_t'(pend_dest));
        end
    endtask

    // drive one instruction and check the one registered at this edge
    task automatic step(input logic v, input word_t ins, input word_t a, input word_t b);
        @(posedge clk);
        in_valid <= v;
        instr    <= ins;
        rs_val   <= a;
        rt_val   <= b;
        @(negedge clk);
        check_outputs();
        model_step(v, ins, a, b);
    endtask

    function automatic word_t make_r(input logic [5:0] fn);
        return {op_special, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom), fn};
    endfunction

    function automatic word_t make_i(input logic [5:0] op);
        return {op, 5'($urandom), 5'($urandom), 16'($urandom)};
    endfunction

    function automatic word_t rand_operand();
        case ($urandom % 8)
            0:       return '0;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h7fff_ffff;
            4:       return word_t'($urandom % 16);
            default: return $urandom;
        endcase
    endfunction

    function automatic word_t gen_instr(input int cls);
        int pick;
        case (cls)
            0: begin
                pick = int'($urandom % 13);
                return (pick < 7) ? make_r(arith_fn[pick]) : make_i(arith_op[pick - 7]);
            end
            1: return make_r(shift_fn[$urandom % 6]);
            2: begin
                pick = int'($urandom % 9);
                if (pick < 2) begin
                    return make_r((pick == 0) ? fn_slt : fn_sltu);
                end else if (pick < 8) begin
                    return make_i(cmp_op[pick - 2]);
                end
                return {op_regimm, 5'($urandom), 5'($urandom % 2), 16'($urandom)};
            end
            3: return make_r(muldiv_fn[$urandom % 4]);
            4: begin
                pick = int'($urandom % 6);
                return (pick < 4) ? make_r(move_fn[pick]) : make_r(muldiv_fn[pick - 4]);
            end
            default: begin
                pick = int'($urandom % 6);
                case (pick)
                    0:       return make_i(op_j);
                    1:       return make_i(op_jal);
                    2:       return make_r(fn_jr);
                    3:       return make_i(6'($urandom % 48 + 16));   // unused opcodes
                    4:       return make_r(undef_fn[$urandom % 4]);
                    default: return {op_regimm, 5'($urandom), 5'($urandom % 30 + 2), 16'($urandom)};
                endcase
            end
        endcase
    endfunction

    task automatic run_test(input int cls, input string name);
        word_t ins;
        word_t a;
        word_t b;
        logic  v;
        test_errs = 0;
        for (int i = 0; i < n_per_test; i++) begin
            v   = ($urandom % 4) != 0;
            ins = gen_instr(cls);
            a   = rand_operand();
            b   = rand_operand();
            case (cls)
                1: begin
                    if ($urandom % 4 != 0) begin
                        a[31] = 1'b1;   // mostly negative
                    end
                end
                2: begin
                    if ($urandom % 4 == 0) begin
                        b = a;
                    end
                end
                3, 4: begin
                    if ($urandom % 8 == 0) begin
                        a = 32'h8000_0000;
                        b = '1;
                    end else if ($urandom % 8 == 0) begin
                        b = '0;
                    end
                end
                default: ;
            endcase
            step(v, ins, a, b);
        end
        step(1'b0, '0, '0, '0);  // flush the last instruction
        $display("test %0d %s finished with %0d errors", cls, name, test_errs);
    endtask

    initial begin
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        instr       = '0;
        rs_val      = '0;
        rt_val      = '0;
        m_hi        = '0;
        m_lo        = '0;
        pend_valid  = 1'b0;
        pend_wen    = 1'b0;
        pend_res    = '0;
        pend_dest   = '0;
        err_count   = 0;
        check_count = 0;
        void'($urandom(91677));
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        run_test(0, "arith_logic");
        run_test(1, "shifts");
        run_test(2, "compare_branch");
        run_test(3, "mul_div");
        run_test(4, "hilo_moves");
        run_test(5, "jump_undef");
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
hw/mips_cpu_pkg.sv
hw/mips_cpu_alu_control.sv
hw/mips_cpu_operand_sel.sv
hw/mips_cpu_alu.sv
hw/mips_cpu_hilo.sv
hw/mips_cpu_stage_reg.sv
hw/mips_cpu_execute.sv
sim/mips_cpu_execute_checker.sv
sim/mips_cpu_execute_tb.sv
